/* Makefile */
SOURCES := verilog.f $(wildcard hdl/*.sv hdl/*.svh dv/*.sv)

.PHONY: run clean

run: obj_dir/Vframe_ingest_tb
	./obj_dir/Vframe_ingest_tb

obj_dir/Vframe_ingest_tb: $(SOURCES)
	verilator --binary --timing --assert -f verilog.f --top-module frame_ingest_tb

clean:
	rm -rf obj_dir

/* dv/frame_ingest_tb.sv */
module frame_ingest_tb;

	typedef logic [7:0] byte_q_t[$];

	localparam int TOTAL_FRAMES = 206;
	localparam int WAIT_LIMIT = 4000;

	logic       clk = 1'b0;
	logic       rst;
	logic       byte_req;
	logic [7:0] byte_data;
	logic       byte_last;
	logic       payload_ack;
	logic       header_done_clear;
	logic       byte_ack;
	logic [7:0] header_eid;
	logic       header_done;
	logic       packet_is_empty;
	logic       is_fragment;
	logic       payload_req;
	logic [7:0] payload_data;

	integer     seed;
	int         sent_len[$];
	logic [7:0] sent_bytes[$];
	logic [9:0] header_q[$]; // {fragment, empty, eid}.
	logic [7:0] got_payload[$];
	int         frames_checked = 0;
	int         clear_hold = 0;
	logic       skip_clear = 1'b0;
	logic       ack_pause = 1'b0;

	frame_ingest_top u_dut (
		.clk               (clk),
		.rst               (rst),
		.byte_req          (byte_req),
		.byte_data         (byte_data),
		.byte_last         (byte_last),
		.payload_ack       (payload_ack),
		.header_done_clear (header_done_clear),
		.byte_ack          (byte_ack),
		.header_eid        (header_eid),
		.header_done       (header_done),
		.packet_is_empty   (packet_is_empty),
		.is_fragment       (is_fragment),
		.payload_req       (payload_req),
		.payload_data      (payload_data)
	);

	initial begin
		forever #2 clk = ~clk;
	end

	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
			$display("Test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out while waiting for %s", what);
		$display("Test failed");
		$fatal(1, "timeout");
	endtask

	function automatic logic [7:0] rand_byte();
		logic [31:0] rnd;
		rnd = $random(seed);
		return rnd[7:0];
	endfunction

	function automatic byte_q_t make_frame(input int len);
		byte_q_t frame;
		for (int i = 0; i < len; i++) begin
			frame.push_back(rand_byte());
		end
		if (len > 3 && frame[2] == 8'h00) begin
			frame[2] = 8'h01; // An empty packet carries no payload.
		end
		return frame;
	endfunction

	// Expected header and payload of one frame.
	function automatic void reference_model(input byte_q_t frame, output logic [7:0] eid,
		output logic empty, output logic frag, output byte_q_t payload);
		payload = {};
		eid = frame[1];
		empty = (frame[2] == 8'h00);
		frag = (frame[2] == 8'hFF);
		for (int i = 3; i < frame.size(); i++) begin
			payload.push_back(frame[i]);
		end
	endfunction

	task automatic send_frame(input byte_q_t frame, input int pause_at, input int pause_len);
		int gap;
		int t;
		sent_len.push_back(frame.size());
		foreach (frame[i]) begin
			sent_bytes.push_back(frame[i]);
		end
		for (int i = 0; i < frame.size(); i++) begin
			gap = {$random(seed)} % 4;
			if (i == pause_at) begin
				gap = pause_len;
			end
			repeat (gap) @(negedge clk);
			byte_data = frame[i];
			byte_last = (i == frame.size() - 1);
			byte_req = 1'b1;
			t = 0;
			while (byte_ack !== 1'b1) begin
				@(negedge clk);
				t++;
				if (t > WAIT_LIMIT) report_timeout("byte_ack to rise");
			end
			@(negedge clk); // Source answers a cycle late.
			byte_req = 1'b0;
			t = 0;
			while (byte_ack !== 1'b0) begin
				@(negedge clk);
				t++;
				if (t > WAIT_LIMIT) report_timeout("byte_ack to fall");
			end
		end
	endtask

	// Host side of the header, sampled once per frame.
	initial begin : header_host
		int   hold;
		logic taken;
		taken = 1'b0;
		forever begin
			@(negedge clk);
			if (header_done !== 1'b1) begin
				taken = 1'b0;
			end else if (!taken) begin
				taken = 1'b1;
				header_q.push_back({is_fragment, packet_is_empty, header_eid});
				hold = clear_hold;
				ack_pause = (hold > 0); // Keeps the frame open.
				repeat (hold) begin
					@(negedge clk);
					check_equal(32'(header_done), 32'd1, "header_done before clear");
				end
				ack_pause = 1'b0;
				if (!skip_clear) begin
					header_done_clear = 1'b1;
					@(negedge clk);
					header_done_clear = 1'b0;
					check_equal(32'(header_done), 32'd0, "header_done after clear");
				end
			end
		end
	end

	initial begin : payload_host
		int t;
		forever begin
			@(negedge clk);
			if (payload_req === 1'b1 && !ack_pause) begin
				got_payload.push_back(payload_data);
				payload_ack = 1'b1;
				t = 0;
				while (payload_req !== 1'b0) begin
					@(negedge clk);
					t++;
					if (t > WAIT_LIMIT) report_timeout("payload_req to fall");
				end
				payload_ack = 1'b0;
			end
		end
	end

	initial begin : compare_frames
		byte_q_t    frame;
		byte_q_t    exp_payload;
		logic [7:0] exp_eid;
		logic       exp_empty;
		logic       exp_frag;
		logic [9:0] hdr;
		int         len;
		int         t;
		repeat (TOTAL_FRAMES) begin
			t = 0;
			while (header_q.size() == 0) begin
				@(negedge clk);
				t++;
				if (t > WAIT_LIMIT) report_timeout("a frame header");
			end
			hdr = header_q.pop_front();
			len = sent_len.pop_front();
			frame = {};
			repeat (len) frame.push_back(sent_bytes.pop_front());
			reference_model(frame, exp_eid, exp_empty, exp_frag, exp_payload);
			check_equal(32'(hdr[7:0]), 32'(exp_eid), "header_eid");
			check_equal(32'(hdr[8]), 32'(exp_empty), "packet_is_empty");
			check_equal(32'(hdr[9]), 32'(exp_frag), "is_fragment");
			foreach (exp_payload[i]) begin
				t = 0;
				while (got_payload.size() == 0) begin
					@(negedge clk);
					t++;
					if (t > WAIT_LIMIT) report_timeout("a payload byte");
				end
				check_equal(32'(got_payload.pop_front()), 32'(exp_payload[i]), "payload byte");
			end
			frames_checked++;
		end
	end

	initial begin : main
		byte_q_t frame;
		int      len;
		int      t;
		seed = 32'hc1fb;
		rst = 1'b1;
		byte_req = 1'b0;
		byte_data = 8'h00;
		byte_last = 1'b0;
		payload_ack = 1'b0;
		header_done_clear = 1'b0;
		repeat (10) @(negedge clk);
		rst = 1'b0;

		frame = make_frame(8);
		if (frame[2] == 8'h00 || frame[2] == 8'hFF) begin
			frame[2] = 8'h10;
		end
		send_frame(frame, -1, 0);
		frame = {};
		frame.push_back(rand_byte());
		frame.push_back(rand_byte());
		frame.push_back(8'h00); // Empty packet.
		send_frame(frame, -1, 0);
		frame = make_frame(12);
		frame[2] = 8'hFF;
		send_frame(frame, -1, 0);
		send_frame(make_frame(20), 10, 30); // Source stalls mid frame.

		clear_hold = 12;
		send_frame(make_frame(10), -1, 0);
		clear_hold = 0;
		skip_clear = 1'b1;
		send_frame(make_frame(10), -1, 0);
		t = 0;
		while (header_done !== 1'b0) begin
			@(negedge clk);
			t++;
			if (t > WAIT_LIMIT) report_timeout("header_done to fall at frame end");
		end
		skip_clear = 1'b0;

		for (int n = 0; n < 200; n++) begin
			len = 3 + ({$random(seed)} % 38);
			send_frame(make_frame(len), -1, 0);
		end

		t = 0;
		while (frames_checked != TOTAL_FRAMES) begin
			@(negedge clk);
			t++;
			if (t > WAIT_LIMIT) report_timeout("the last frame to be checked");
		end
		if (header_q.size() != 0 || got_payload.size() != 0 || payload_req !== 1'b0) begin
			$display("Extra header or payload bytes came out after the last frame");
			$display("Test failed");
			$fatal(1, "leftover output");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

/* hdl/frame_buffer.sv */
`include "ice_config.svh"

module frame_buffer
	import ice_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     wr_en,
	input  logic [7:0]               wr_data,
	input  logic [`FRAME_ADDR_W-1:0] in_frame_addr,
	input  logic [`FRAME_ADDR_W-1:0] rd_addr,
	input  logic                     in_frame_latch_tail,
	output frame_word_t              in_frame_data,
	output frame_word_t              rd_data,
	output logic [`FRAME_ADDR_W-1:0] in_frame_tail,
	output logic                     full
);

	logic [7:0]               mem [`FRAME_DEPTH];
	logic [`FRAME_ADDR_W-1:0] head;
	logic [`FRAME_ADDR_W-1:0] tail;
	logic [`FRAME_ADDR_W-1:0] head_next;

	assign head_next = head + 1'b1;
	assign full = (head_next == tail); // One slot always stays open.
	assign in_frame_tail = tail;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[head] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
		end else begin
			if (wr_en) begin
				head <= head_next;
			end
			if (in_frame_latch_tail) begin
				tail <= head; // Frame is done, give its space back.
			end
		end
	end

	// Both ports read in place, head marks the first word not yet written.
	assign in_frame_data = '{unwritten: (in_frame_addr == head), data: mem[in_frame_addr]};
	assign rd_data = '{unwritten: (rd_addr == head), data: mem[rd_addr]};

	no_write_when_full: assert property (
		@(posedge clk) disable iff (rst) wr_en |-> !full
	);

endmodule

/* hdl/frame_ingest_top.sv */
`include "ice_config.svh"

module frame_ingest_top
	import ice_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       byte_req,
	input  logic [7:0] byte_data,
	input  logic       byte_last,
	input  logic       payload_ack,
	input  logic       header_done_clear,
	output logic       byte_ack,
	output logic [7:0] header_eid,
	output logic       header_done,
	output logic       packet_is_empty,
	output logic       is_fragment,
	output logic       payload_req,
	output logic [7:0] payload_data
);

	logic                     wr_en;
	logic [7:0]               wr_data;
	logic                     full;
	logic                     frame_valid;
	logic                     frame_closed;
	logic                     frame_release;
	logic [`FRAME_ADDR_W-1:0] in_frame_addr;
	logic [`FRAME_ADDR_W-1:0] rd_addr;
	logic [`FRAME_ADDR_W-1:0] in_frame_tail;
	logic                     in_frame_latch_tail;
	logic                     in_frame_next;
	frame_word_t              in_frame_data;
	frame_word_t              rd_data;

	frame_buffer u_buffer (
		.clk                 (clk),
		.rst                 (rst),
		.wr_en               (wr_en),
		.wr_data             (wr_data),
		.in_frame_addr       (in_frame_addr),
		.rd_addr             (rd_addr),
		.in_frame_latch_tail (in_frame_latch_tail),
		.in_frame_data       (in_frame_data),
		.rd_data             (rd_data),
		.in_frame_tail       (in_frame_tail),
		.full                (full)
	);

	frame_writer u_writer (
		.clk           (clk),
		.rst           (rst),
		.byte_req      (byte_req),
		.byte_data     (byte_data),
		.byte_last     (byte_last),
		.full          (full),
		.frame_release (frame_release),
		.byte_ack      (byte_ack),
		.wr_en         (wr_en),
		.wr_data       (wr_data),
		.frame_valid   (frame_valid),
		.frame_closed  (frame_closed)
	);

	header_decoder u_decoder (
		.clk                 (clk),
		.rst                 (rst),
		.in_frame_data       (in_frame_data),
		.in_frame_valid      (frame_valid),
		.in_frame_tail       (in_frame_tail),
		.in_frame_next       (in_frame_next),
		.header_done_clear   (header_done_clear),
		.in_frame_addr       (in_frame_addr),
		.in_frame_latch_tail (in_frame_latch_tail),
		.header_eid          (header_eid),
		.header_done         (header_done),
		.packet_is_empty     (packet_is_empty),
		.is_fragment         (is_fragment)
	);

	payload_reader u_reader (
		.clk             (clk),
		.rst             (rst),
		.header_done     (header_done),
		.packet_is_empty (packet_is_empty),
		.frame_closed    (frame_closed),
		.rd_data         (rd_data),
		.in_frame_tail   (in_frame_tail),
		.payload_ack     (payload_ack),
		.rd_addr         (rd_addr),
		.in_frame_next   (in_frame_next),
		.payload_req     (payload_req),
		.payload_data    (payload_data),
		.frame_release   (frame_release)
	);

endmodule

/* hdl/frame_writer.sv */
`include "ice_config.svh"

module frame_writer
	import ice_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       byte_req,
	input  logic [7:0] byte_data,
	input  logic       byte_last,
	input  logic       full,
	input  logic       frame_release,
	output logic       byte_ack,
	output logic       wr_en,
	output logic [7:0] wr_data,
	output logic       frame_valid,
	output logic       frame_closed
);

	wr_state_t state;
	logic      last_seen;

	assign wr_en = (state == wr_idle) && byte_req && !full; // Held off while full.
	assign wr_data = byte_data;
	assign byte_ack = (state == wr_ack);
	assign frame_closed = (state == wr_closed);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= wr_idle;
			frame_valid <= 1'b0;
			last_seen <= 1'b0;
		end else begin
			case (state)
				wr_idle: begin
					if (wr_en) begin
						state <= wr_ack;
						frame_valid <= 1'b1; // Opens on the first byte.
						last_seen <= byte_last;
					end
				end
				wr_ack: begin
					if (!byte_req) begin
						state <= last_seen ? wr_closed : wr_idle;
					end
				end
				wr_closed: begin
					if (frame_release) begin
						state <= wr_idle;
						frame_valid <= 1'b0;
					end
				end
				default: state <= wr_idle;
			endcase
		end
	end

	ack_follows_req: assert property (
		@(posedge clk) disable iff (rst) $rose(byte_ack) |-> byte_req
	);

endmodule

/* hdl/header_decoder.sv */
`include "ice_config.svh"

module header_decoder
	import ice_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  frame_word_t              in_frame_data,
	input  logic                     in_frame_valid,
	input  logic [`FRAME_ADDR_W-1:0] in_frame_tail,
	input  logic                     in_frame_next,
	input  logic                     header_done_clear,
	output logic [`FRAME_ADDR_W-1:0] in_frame_addr,
	output logic                     in_frame_latch_tail,
	output logic [7:0]               header_eid,
	output logic                     header_done,
	output logic                     packet_is_empty,
	output logic                     is_fragment
);

	hdr_state_t               state;
	hdr_state_t               next_state;
	logic [`FRAME_ADDR_W-1:0] addr_offset;
	logic                     frame_data_latch;
	logic                     latch_eid;
	logic                     set_header_done;
	logic                     data_written;

	assign data_written = !in_frame_data.unwritten;
	assign in_frame_addr = in_frame_tail + addr_offset;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= hdr_idle;
			header_done <= 1'b0;
			packet_is_empty <= 1'b0;
			is_fragment <= 1'b0;
			addr_offset <= '0;
		end else begin
			state <= next_state;

			// Restart at the prefix, or step past it right away.
			if (state == hdr_idle) begin
				addr_offset <= {{(`FRAME_ADDR_W-1){1'b0}}, frame_data_latch};
			end else if (frame_data_latch || in_frame_next) begin
				addr_offset <= addr_offset + 1'b1;
			end

			if (set_header_done) begin
				header_done <= 1'b1;
				packet_is_empty <= (in_frame_data.data == `HDR_EMPTY_MARK);
				is_fragment <= (in_frame_data.data == `HDR_FRAGMENT_MARK);
			end
			if (header_done_clear || !in_frame_valid) begin
				header_done <= 1'b0; // Clear wins over set.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (latch_eid) begin
			header_eid <= in_frame_data.data;
		end
	end

	always_comb begin
		next_state = state;
		in_frame_latch_tail = 1'b0;
		frame_data_latch = 1'b0;
		latch_eid = 1'b0;
		set_header_done = 1'b0;

		case (state)
			hdr_idle: begin
				frame_data_latch = in_frame_valid; // Prefix is not read.
				if (in_frame_valid) begin
					next_state = hdr_record_eid;
				end
			end
			hdr_record_eid: begin
				frame_data_latch = data_written;
				latch_eid = data_written;
				if (data_written) begin
					next_state = hdr_skip_len;
				end
			end
			hdr_skip_len: begin
				frame_data_latch = data_written;
				set_header_done = data_written;
				if (data_written) begin
					next_state = hdr_wait;
				end
			end
			hdr_wait: begin
				// Reader has released the frame.
				if (!in_frame_valid) begin
					in_frame_latch_tail = 1'b1;
					next_state = hdr_idle;
				end
			end
			default: next_state = hdr_idle;
		endcase
	end

	// Offset has followed every payload byte up to the end of the frame.
	latch_after_frame_end: assert property (
		@(posedge clk) disable iff (rst)
		in_frame_latch_tail |->
			!in_frame_valid && (packet_is_empty || in_frame_data.unwritten)
	);

endmodule

/* hdl/ice_config.svh */
`ifndef ICE_CONFIG_SVH
`define ICE_CONFIG_SVH

// Ring buffer geometry.
`define FRAME_ADDR_W 9
`define FRAME_DEPTH 512

// Length/flag byte values with a special meaning.
`define HDR_EMPTY_MARK 8'h00
`define HDR_FRAGMENT_MARK 8'hFF

`endif

/* hdl/ice_pkg.sv */
package ice_pkg;

	typedef struct packed {
		logic       unwritten; // Address equals head.
		logic [7:0] data;
	} frame_word_t;

	typedef enum logic [1:0] {
		hdr_idle,
		hdr_record_eid,
		hdr_skip_len,
		hdr_wait
	} hdr_state_t;

	typedef enum logic [1:0] {
		wr_idle,
		wr_ack,
		wr_closed
	} wr_state_t;

	typedef enum logic [1:0] {
		rd_idle,
		rd_fetch,
		rd_req,
		rd_ack_wait
	} rd_state_t;

endpackage

/* hdl/payload_reader.sv */
`include "ice_config.svh"

module payload_reader
	import ice_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     header_done,
	input  logic                     packet_is_empty,
	input  logic                     frame_closed,
	input  frame_word_t              rd_data,
	input  logic [`FRAME_ADDR_W-1:0] in_frame_tail,
	input  logic                     payload_ack,
	output logic [`FRAME_ADDR_W-1:0] rd_addr,
	output logic                     in_frame_next,
	output logic                     payload_req,
	output logic [7:0]               payload_data,
	output logic                     frame_release
);

	rd_state_t                state;
	logic [`FRAME_ADDR_W-1:0] rd_offset;
	logic                     hold_off;

	assign rd_addr = in_frame_tail + rd_offset + 2'd3; // Payload follows the header.
	assign payload_req = (state == rd_req);
	assign in_frame_next = (state == rd_ack_wait) && !payload_ack;
	assign frame_release = (state == rd_fetch) && frame_closed &&
		(packet_is_empty || rd_data.unwritten);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= rd_idle;
			rd_offset <= '0;
			hold_off <= 1'b0;
		end else begin
			case (state)
				rd_idle: begin
					rd_offset <= '0;
					if (header_done && !hold_off) begin
						state <= rd_fetch;
					end
				end
				rd_fetch: begin
					if (frame_release) begin
						state <= rd_idle;
					end else if (!packet_is_empty && !rd_data.unwritten) begin
						state <= rd_req;
					end
				end
				rd_req: begin
					if (payload_ack) begin
						state <= rd_ack_wait;
					end
				end
				rd_ack_wait: begin
					if (!payload_ack) begin
						state <= rd_fetch;
						rd_offset <= rd_offset + 1'b1;
					end
				end
				default: state <= rd_idle;
			endcase

			// header_done of the released frame lingers a couple of cycles.
			if (frame_release) begin
				hold_off <= 1'b1;
			end else if (!header_done) begin
				hold_off <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == rd_fetch && !rd_data.unwritten) begin
			payload_data <= rd_data.data;
		end
	end

	// Presented byte stays the buffer word until the host takes it.
	data_stable_in_req: assert property (
		@(posedge clk) disable iff (rst)
		payload_req |-> !rd_data.unwritten && (payload_data == rd_data.data)
	);

endmodule

/* verilog.f */
+incdir+hdl
hdl/ice_pkg.sv
hdl/frame_buffer.sv
hdl/frame_writer.sv
hdl/header_decoder.sv
hdl/payload_reader.sv
hdl/frame_ingest_top.sv
dv/frame_ingest_tb.sv
